//--- common/lsu_pkg.sv
package lsu_pkg;

    // ------------------------------------------------------------
    // memory and register file sizes
    // ------------------------------------------------------------
    localparam int DM_WORDS = 64;                // data memory depth in words
    localparam int DM_AW    = $clog2(DM_WORDS);  // word address width
    localparam int REG_NUM  = 32;
    localparam int REG_AW   = $clog2(REG_NUM);   // register number width

    // ------------------------------------------------------------
    // instruction opcodes seen by the back end
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ALU  = 4'd1,   // plain alu result write
        OP_LB   = 4'd2,
        OP_LBU  = 4'd3,
        OP_LH   = 4'd4,
        OP_LHU  = 4'd5,
        OP_LW   = 4'd6,
        OP_LWL  = 4'd7,   // unaligned word, left part
        OP_LWR  = 4'd8,   // unaligned word, right part
        OP_SB   = 4'd9,
        OP_SH   = 4'd10,
        OP_SW   = 4'd11
    } lsu_op_e;

    // ------------------------------------------------------------
    // write-back source
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        WB_NONE  = 2'd0,  // stores and nop
        WB_ALU   = 2'd1,
        WB_EXT   = 2'd2,  // extracted load
        WB_MERGE = 2'd3   // rotated word for lwl / lwr
    } wb_sel_e;

    // ------------------------------------------------------------
    // load extraction kind
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        EXT_BYTE_S = 3'd0,
        EXT_BYTE_U = 3'd1,
        EXT_HALF_S = 3'd2,
        EXT_HALF_U = 3'd3,
        EXT_WORD   = 3'd4
    } ext_ctl_e;

endpackage

//--- src/load_decode.sv
module load_decode import lsu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  lsu_op_e           in_op,
    input  logic [31:0]       in_pc,
    input  logic [31:0]       in_addr,
    input  logic [31:0]       in_alu_result,
    input  logic [31:0]       in_store_data,
    input  logic [REG_AW-1:0] in_wnum,
    output logic              ex_valid,
    output logic [31:0]       ex_pc,
    output logic [DM_AW-1:0]  ex_word_addr,
    output logic [1:0]        ex_adrl,
    output logic [3:0]        ex_store_be,
    output logic [31:0]       ex_store_data,
    output logic [31:0]       ex_alu_result,
    output ext_ctl_e          ex_ext_ctl,
    output wb_sel_e           ex_wb_sel,
    output logic              ex_merge_left,
    output logic [REG_AW-1:0] ex_wnum
);

    logic [1:0]  adrl;
    logic [3:0]  store_be;
    logic [31:0] store_lanes;
    ext_ctl_e    ext_ctl;
    wb_sel_e     wb_sel;

    assign adrl = in_addr[1:0];

    // ------------------------------------------------------------
    // opcode decode
    // ------------------------------------------------------------
    always_comb begin
        store_be    = 4'b0000;
        store_lanes = in_store_data;
        ext_ctl     = EXT_WORD;
        wb_sel      = WB_NONE;
        case (in_op)
            OP_ALU: wb_sel = WB_ALU;
            OP_LB:  begin ext_ctl = EXT_BYTE_S; wb_sel = WB_EXT; end
            OP_LBU: begin ext_ctl = EXT_BYTE_U; wb_sel = WB_EXT; end
            OP_LH:  begin ext_ctl = EXT_HALF_S; wb_sel = WB_EXT; end
            OP_LHU: begin ext_ctl = EXT_HALF_U; wb_sel = WB_EXT; end
            OP_LW:  wb_sel = WB_EXT;
            OP_LWL, OP_LWR: wb_sel = WB_MERGE;
            OP_SB: begin
                store_be    = 4'b0001 << adrl;
                store_lanes = {4{in_store_data[7:0]}};   // byte in every lane
            end
            OP_SH: begin
                store_be    = adrl[1] ? 4'b1100 : 4'b0011;
                store_lanes = {2{in_store_data[15:0]}};
            end
            OP_SW:   store_be = 4'b1111;
            default: ;   // nop
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || !in_valid) begin
            ex_valid      <= 1'b0;
            ex_pc         <= '0;
            ex_word_addr  <= '0;
            ex_adrl       <= '0;
            ex_store_be   <= '0;
            ex_store_data <= '0;
            ex_alu_result <= '0;
            ex_ext_ctl    <= EXT_BYTE_S;
            ex_wb_sel     <= WB_NONE;
            ex_merge_left <= 1'b0;
            ex_wnum       <= '0;
        end else begin
            ex_valid      <= 1'b1;
            ex_pc         <= in_pc;
            ex_word_addr  <= in_addr[DM_AW+1:2];   // upper bits ignored
            ex_adrl       <= adrl;
            ex_store_be   <= store_be;
            ex_store_data <= store_lanes;
            ex_alu_result <= in_alu_result;
            ex_ext_ctl    <= ext_ctl;
            ex_wb_sel     <= wb_sel;
            ex_merge_left <= (in_op == OP_LWL);
            ex_wnum       <= in_wnum;
        end
    end

    // source must hand over aligned half and word accesses
    a_half_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && (in_op inside {OP_LH, OP_LHU, OP_SH}) |-> !in_addr[0]);
    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && (in_op inside {OP_LW, OP_SW}) |-> in_addr[1:0] == 2'b00);

endmodule

//--- mem_stage/mem_stage.sv
module mem_stage import lsu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ex_valid,
    input  logic [31:0]       ex_pc,
    input  logic [DM_AW-1:0]  ex_word_addr,
    input  logic [1:0]        ex_adrl,
    input  logic [3:0]        ex_store_be,
    input  logic [31:0]       ex_store_data,
    input  logic [31:0]       ex_alu_result,
    input  ext_ctl_e          ex_ext_ctl,
    input  wb_sel_e           ex_wb_sel,
    input  logic              ex_merge_left,
    input  logic [REG_AW-1:0] ex_wnum,
    output logic              mem_valid,
    output logic [31:0]       mem_pc,
    output logic [31:0]       mem_rdata,
    output logic [1:0]        mem_adrl,
    output logic [31:0]       mem_alu_result,
    output ext_ctl_e          mem_ext_ctl,
    output wb_sel_e           mem_wb_sel,
    output logic              mem_merge_left,
    output logic [REG_AW-1:0] mem_wnum
);

    logic [31:0] dmem [DM_WORDS];

    logic is_store;
    logic is_load;

    assign is_store = ex_valid && (ex_store_be != 4'b0000);
    assign is_load  = ex_valid && (ex_wb_sel inside {WB_EXT, WB_MERGE});

    // ------------------------------------------------------------
    // data memory, byte lane writes
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (is_store) begin
            for (int i = 0; i < 4; i++) begin
                if (ex_store_be[i])
                    dmem[ex_word_addr][8*i +: 8] <= ex_store_data[8*i +: 8];
            end
        end
    end

    // ------------------------------------------------------------
    // read word and control pipeline register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n || !ex_valid) begin
            mem_valid      <= 1'b0;
            mem_pc         <= '0;
            mem_rdata      <= '0;
            mem_adrl       <= '0;
            mem_alu_result <= '0;
            mem_ext_ctl    <= EXT_BYTE_S;
            mem_wb_sel     <= WB_NONE;
            mem_merge_left <= 1'b0;
            mem_wnum       <= '0;
        end else begin
            mem_valid      <= 1'b1;
            mem_pc         <= ex_pc;
            mem_rdata      <= is_load ? dmem[ex_word_addr] : 32'h0;
            mem_adrl       <= ex_adrl;
            mem_alu_result <= ex_alu_result;
            mem_ext_ctl    <= ex_ext_ctl;
            mem_wb_sel     <= ex_wb_sel;
            mem_merge_left <= ex_merge_left;
            mem_wnum       <= ex_wnum;
        end
    end

    // a store must never reach the register file
    a_store_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
        is_store |-> ex_wb_sel == WB_NONE);

endmodule

//--- wb/load_align.sv
module load_align import lsu_pkg::*; (
    input  logic [31:0] word,
    input  logic [1:0]  adrl,
    input  ext_ctl_e    ext_ctl,
    output logic [31:0] ext_out
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    assign byte_sel = word[8*adrl +: 8];
    assign half_sel = adrl[1] ? word[31:16] : word[15:0];   // bit 0 assumed zero

    always_comb begin
        case (ext_ctl)
            EXT_BYTE_S: ext_out = {{24{byte_sel[7]}}, byte_sel};
            EXT_BYTE_U: ext_out = {24'h0, byte_sel};
            EXT_HALF_S: ext_out = {{16{half_sel[15]}}, half_sel};
            EXT_HALF_U: ext_out = {16'h0, half_sel};
            default:    ext_out = word;   // full word
        endcase
    end

endmodule

//--- wb/wb_stage.sv
module wb_stage import lsu_pkg::*; (
    input  logic              mem_valid,
    input  logic [31:0]       mem_pc,
    input  logic [31:0]       mem_rdata,
    input  logic [1:0]        mem_adrl,
    input  logic [31:0]       mem_alu_result,
    input  ext_ctl_e          mem_ext_ctl,
    input  wb_sel_e           mem_wb_sel,
    input  logic              mem_merge_left,
    input  logic [REG_AW-1:0] mem_wnum,
    output logic              wb_valid,
    output logic [31:0]       wb_pc,
    output logic [REG_AW-1:0] wb_wnum,
    output logic [31:0]       wb_wdata,
    output logic [3:0]        wb_we
);

    logic [31:0] ext_word;
    logic [1:0]  rot_n;       // rotate right amount in bytes
    logic [63:0] rot_dbl;
    logic [31:0] merge_word;
    logic [3:0]  merge_mask;

    // ------------------------------------------------------------
    // byte and half extraction
    // ------------------------------------------------------------
    load_align u_load_align (
        .word    (mem_rdata),
        .adrl    (mem_adrl),
        .ext_ctl (mem_ext_ctl),
        .ext_out (ext_word)
    );

    // ------------------------------------------------------------
    // lwl / lwr rotate and mask
    // ------------------------------------------------------------
    // lwl rotates left by 3-a, which is right by a+1 mod 4
    assign rot_n      = mem_merge_left ? mem_adrl + 2'd1 : mem_adrl;
    assign rot_dbl    = {mem_rdata, mem_rdata} >> {rot_n, 3'b000};
    assign merge_word = rot_dbl[31:0];

    always_comb begin
        if (mem_merge_left)
            merge_mask = 4'b1111 << (2'd3 - mem_adrl);   // upper a+1 bytes
        else
            merge_mask = 4'b1111 >> mem_adrl;            // lower 4-a bytes
    end

    // ------------------------------------------------------------
    // write-back select
    // ------------------------------------------------------------
    always_comb begin
        case (mem_wb_sel)
            WB_ALU:   wb_wdata = mem_alu_result;
            WB_EXT:   wb_wdata = ext_word;
            WB_MERGE: wb_wdata = merge_word;
            default:  wb_wdata = 32'h0;
        endcase
    end

    always_comb begin
        if (!mem_valid) begin
            wb_we = 4'b0000;
        end else begin
            case (mem_wb_sel)
                WB_ALU, WB_EXT: wb_we = 4'b1111;
                WB_MERGE:       wb_we = merge_mask;
                default:        wb_we = 4'b0000;   // store or nop
            endcase
        end
    end

    // trace outputs
    assign wb_valid = mem_valid;
    assign wb_pc    = mem_pc;
    assign wb_wnum  = mem_wnum;

endmodule

//--- src/reg_file.sv
module reg_file import lsu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [REG_AW-1:0] wnum,
    input  logic [31:0]       wdata,
    input  logic [3:0]        we,
    input  logic [REG_AW-1:0] rd_num,
    output logic [31:0]       rd_data
);

    logic [31:0] regs [REG_NUM];

    // ------------------------------------------------------------
    // write port, one enable per byte lane
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < REG_NUM; r++)
                regs[r] <= 32'h0;
        end else if (wnum != '0) begin   // r0 stays zero
            for (int i = 0; i < 4; i++) begin
                if (we[i])
                    regs[wnum][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    assign rd_data = regs[rd_num];   // combinational read

endmodule

//--- src/lsu_top.sv
module lsu_top import lsu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  lsu_op_e           in_op,
    input  logic [31:0]       in_pc,
    input  logic [31:0]       in_addr,
    input  logic [31:0]       in_alu_result,
    input  logic [31:0]       in_store_data,
    input  logic [REG_AW-1:0] in_wnum,
    input  logic [REG_AW-1:0] rd_num,
    output logic              wb_valid,
    output logic [31:0]       wb_pc,
    output logic [REG_AW-1:0] wb_wnum,
    output logic [31:0]       wb_wdata,
    output logic [3:0]        wb_we,
    output logic [31:0]       rd_data
);

    // decode to execute
    logic              ex_valid;
    logic [31:0]       ex_pc;
    logic [DM_AW-1:0]  ex_word_addr;
    logic [1:0]        ex_adrl;
    logic [3:0]        ex_store_be;
    logic [31:0]       ex_store_data;
    logic [31:0]       ex_alu_result;
    ext_ctl_e          ex_ext_ctl;
    wb_sel_e           ex_wb_sel;
    logic              ex_merge_left;
    logic [REG_AW-1:0] ex_wnum;

    // execute to result
    logic              mem_valid;
    logic [31:0]       mem_pc;
    logic [31:0]       mem_rdata;
    logic [1:0]        mem_adrl;
    logic [31:0]       mem_alu_result;
    ext_ctl_e          mem_ext_ctl;
    wb_sel_e           mem_wb_sel;
    logic              mem_merge_left;
    logic [REG_AW-1:0] mem_wnum;

    // ------------------------------------------------------------
    load_decode u_load_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_op         (in_op),
        .in_pc         (in_pc),
        .in_addr       (in_addr),
        .in_alu_result (in_alu_result),
        .in_store_data (in_store_data),
        .in_wnum       (in_wnum),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_word_addr  (ex_word_addr),
        .ex_adrl       (ex_adrl),
        .ex_store_be   (ex_store_be),
        .ex_store_data (ex_store_data),
        .ex_alu_result (ex_alu_result),
        .ex_ext_ctl    (ex_ext_ctl),
        .ex_wb_sel     (ex_wb_sel),
        .ex_merge_left (ex_merge_left),
        .ex_wnum       (ex_wnum)
    );

    mem_stage u_mem_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_valid       (ex_valid),
        .ex_pc          (ex_pc),
        .ex_word_addr   (ex_word_addr),
        .ex_adrl        (ex_adrl),
        .ex_store_be    (ex_store_be),
        .ex_store_data  (ex_store_data),
        .ex_alu_result  (ex_alu_result),
        .ex_ext_ctl     (ex_ext_ctl),
        .ex_wb_sel      (ex_wb_sel),
        .ex_merge_left  (ex_merge_left),
        .ex_wnum        (ex_wnum),
        .mem_valid      (mem_valid),
        .mem_pc         (mem_pc),
        .mem_rdata      (mem_rdata),
        .mem_adrl       (mem_adrl),
        .mem_alu_result (mem_alu_result),
        .mem_ext_ctl    (mem_ext_ctl),
        .mem_wb_sel     (mem_wb_sel),
        .mem_merge_left (mem_merge_left),
        .mem_wnum       (mem_wnum)
    );

    wb_stage u_wb_stage (
        .mem_valid      (mem_valid),
        .mem_pc         (mem_pc),
        .mem_rdata      (mem_rdata),
        .mem_adrl       (mem_adrl),
        .mem_alu_result (mem_alu_result),
        .mem_ext_ctl    (mem_ext_ctl),
        .mem_wb_sel     (mem_wb_sel),
        .mem_merge_left (mem_merge_left),
        .mem_wnum       (mem_wnum),
        .wb_valid       (wb_valid),
        .wb_pc          (wb_pc),
        .wb_wnum        (wb_wnum),
        .wb_wdata       (wb_wdata),
        .wb_we          (wb_we)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .wnum    (wb_wnum),
        .wdata   (wb_wdata),
        .we      (wb_we),
        .rd_num  (rd_num),
        .rd_data (rd_data)
    );

endmodule

//--- dv/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // period 20
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- dv/tb_lsu.sv
module tb_lsu import lsu_pkg::*; ();

    localparam int N_RAND     = 300;
    localparam int MAX_CYCLES = 4 + 2 * REG_NUM + DM_WORDS + 80 + N_RAND + 20;
    localparam int TIMEOUT    = MAX_CYCLES * 20 + 1000;

    logic clk, rst_n;
    logic in_valid;
    lsu_op_e in_op;
    logic [31:0] in_pc, in_addr, in_alu_result, in_store_data;
    logic [REG_AW-1:0] in_wnum, rd_num;
    logic wb_valid;
    logic [31:0] wb_pc, wb_wdata, rd_data;
    logic [REG_AW-1:0] wb_wnum;
    logic [3:0] wb_we;

    // reference model state
    logic [31:0] model_mem [DM_WORDS];
    logic [31:0] model_regs [REG_NUM];
    logic [31:0] q_pc[$], q_wdata[$], q_reg[$];
    logic [3:0]  q_we[$];
    logic [REG_AW-1:0] q_wnum[$];
    logic [31:0] seed = 32'd36;
    logic [31:0] pc = 32'h0000_1000;

    // monitor state
    logic [1:0]  vhist = 2'b00;   // in_valid seen at the last two negedges
    logic        req_valid = 1'b0, rd_chk = 1'b0;
    logic [REG_AW-1:0] req_num;
    logic [31:0] req_val, rd_chk_val, e_pc, e_wdata, e_reg;
    logic [3:0]  e_we;
    logic [REG_AW-1:0] e_wnum;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    lsu_top i_lsu_top (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_op(in_op), .in_pc(in_pc),
        .in_addr(in_addr), .in_alu_result(in_alu_result), .in_store_data(in_store_data),
        .in_wnum(in_wnum), .rd_num(rd_num), .wb_valid(wb_valid), .wb_pc(wb_pc),
        .wb_wnum(wb_wnum), .wb_wdata(wb_wdata), .wb_we(wb_we), .rd_data(rd_data)
    );

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] rand32();
        seed = seed * 32'd1664525 + 32'd1013904223;   // lcg step
        return seed;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    // ------------------------------------------------------------
    // reference model, applied in issue order
    // ------------------------------------------------------------
    task automatic model_apply(input lsu_op_e op, input logic [31:0] addr,
                               input logic [31:0] alu, input logic [31:0] sdata,
                               input logic [REG_AW-1:0] wnum,
                               output logic [31:0] wdata, output logic [3:0] we);
        logic [DM_AW-1:0] w;
        int a;
        logic [31:0] m;
        logic [7:0]  b;
        logic [15:0] h;
        w = addr[DM_AW+1:2];
        a = int'(addr[1:0]);
        m = model_mem[w];
        b = m[8*a +: 8];
        h = m[16*(a/2) +: 16];
        wdata = 32'h0;
        we    = 4'h0;
        case (op)
            OP_ALU: begin
                wdata = alu;
                we    = 4'hf;
            end
            OP_LB: begin
                wdata = {{24{b[7]}}, b};
                we    = 4'hf;
            end
            OP_LBU: begin
                wdata = {24'h0, b};
                we    = 4'hf;
            end
            OP_LH: begin
                wdata = {{16{h[15]}}, h};
                we    = 4'hf;
            end
            OP_LHU: begin
                wdata = {16'h0, h};
                we    = 4'hf;
            end
            OP_LW: begin
                wdata = m;
                we    = 4'hf;
            end
            OP_LWL: begin
                for (int k = 0; k < 4; k++) begin   // rotate left by 3-a bytes
                    wdata[8*k +: 8] = m[8*((k + 4 - (3 - a)) % 4) +: 8];
                    we[k] = (k >= 4 - (a + 1));      // upper a+1 bytes
                end
            end
            OP_LWR: begin
                for (int k = 0; k < 4; k++) begin   // rotate right by a bytes
                    wdata[8*k +: 8] = m[8*((k + a) % 4) +: 8];
                    we[k] = (k < 4 - a);             // lower 4-a bytes
                end
            end
            OP_SB:   model_mem[w][8*a +: 8] = sdata[7:0];
            OP_SH:   model_mem[w][16*(a/2) +: 16] = sdata[15:0];
            OP_SW:   model_mem[w] = sdata;
            default: ;
        endcase
        if (wnum != 0) begin
            for (int k = 0; k < 4; k++)
                if (we[k]) model_regs[wnum][8*k +: 8] = wdata[8*k +: 8];
        end
    endtask

    // ------------------------------------------------------------
    // stimulus tasks
    // ------------------------------------------------------------
    task automatic issue(input lsu_op_e op, input logic [31:0] addr, input logic [31:0] alu,
                         input logic [31:0] sdata, input logic [REG_AW-1:0] wnum);
        logic [31:0] wdata;
        logic [3:0]  we;
        @(posedge clk);
        in_valid      <= 1'b1;
        in_op         <= op;
        in_pc         <= pc;
        in_addr       <= addr;
        in_alu_result <= alu;
        in_store_data <= sdata;
        in_wnum       <= wnum;
        model_apply(op, addr, alu, sdata, wnum, wdata, we);
        q_pc.push_back(pc);
        q_wnum.push_back(wnum);
        q_wdata.push_back(wdata);
        q_we.push_back(we);
        q_reg.push_back(model_regs[wnum]);
        pc = pc + 32'd4;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
            in_op    <= OP_NOP;
        end
    endtask

    task automatic sweep_regs();
        for (int r = 0; r < REG_NUM; r++) begin
            @(posedge clk);
            rd_num <= REG_AW'(r);
            @(negedge clk);
            check_value($sformatf("rd_data[%0d]", r), rd_data, model_regs[r]);
        end
    endtask

    task automatic random_instr();
        logic [31:0] r, hi;
        logic [31:0] alu, sdata;
        lsu_op_e op;
        logic [1:0] lane;
        r     = rand32();
        hi    = rand32();
        alu   = rand32();
        sdata = rand32();
        op    = lsu_op_e'(r[23:16] % 12);
        lane  = r[9:8];
        if (op inside {OP_LH, OP_LHU, OP_SH}) lane[0] = 1'b0;
        if (op inside {OP_LW, OP_SW}) lane = 2'b00;
        issue(op, {hi[31:DM_AW+2], r[DM_AW+1+10:12], lane}, alu, sdata, r[4:0]);
    endtask

    // ------------------------------------------------------------
    // write-back monitor, sampled at the falling edge
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            if (rd_chk) check_value("rd_data", rd_data, rd_chk_val);
            check_value("wb_valid", 32'(wb_valid), 32'(vhist[1]));   // fixed 2 cycle latency
            req_valid = 1'b0;
            if (wb_valid) begin
                if (q_pc.size() == 0) begin
                    fail_run("write-back seen with no instruction outstanding");
                end else begin
                    e_pc    = q_pc.pop_front();
                    e_wnum  = q_wnum.pop_front();
                    e_wdata = q_wdata.pop_front();
                    e_we    = q_we.pop_front();
                    e_reg   = q_reg.pop_front();
                    check_value("wb_pc", wb_pc, e_pc);
                    check_value("wb_wnum", 32'(wb_wnum), 32'(e_wnum));
                    check_value("wb_we", 32'(wb_we), 32'(e_we));
                    if (e_we != 4'h0) check_value("wb_wdata", wb_wdata, e_wdata);
                    req_valid = 1'b1;
                    req_num   = e_wnum;
                    req_val   = e_reg;
                end
            end else begin
                check_value("wb_we", 32'(wb_we), 32'h0);
            end
            vhist = {vhist[0], in_valid};
        end
    end

    // read back the destination once the write has committed
    always @(posedge clk) begin
        rd_chk     <= req_valid;
        rd_chk_val <= req_val;
        if (req_valid) rd_num <= req_num;
    end

    initial begin
        #(TIMEOUT);
        fail_run("timeout, the run did not finish within its cycle limit");
    end

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin
        in_valid      = 1'b0;
        in_op         = OP_NOP;
        in_pc         = '0;
        in_addr       = '0;
        in_alu_result = '0;
        in_store_data = '0;
        in_wnum       = '0;
        rd_num        = '0;
        for (int r = 0; r < REG_NUM; r++) model_regs[r] = 32'h0;
        wait (rst_n);
        sweep_regs();   // all zero after reset

        for (int w = 0; w < DM_WORDS; w++)   // fill memory
            issue(OP_SW, w << 2, 32'h0, rand32() ^ (w * 32'h0101_0101), 5'd0);

        // store then loads of each width, first load right behind the store
        issue(OP_SW, 32'd10 << 2, 32'h0, 32'h8a7f_c3e1, 5'd0);
        for (int a = 0; a < 4; a++) begin
            issue(OP_LB, (32'd10 << 2) + a, 32'h0, 32'h0, REG_AW'(1 + a));
            issue(OP_LBU, (32'd10 << 2) + a, 32'h0, 32'h0, REG_AW'(5 + a));
        end
        for (int a = 0; a < 4; a += 2) begin
            issue(OP_LH, (32'd10 << 2) + a, 32'h0, 32'h0, 5'd9);
            issue(OP_LHU, (32'd10 << 2) + a, 32'h0, 32'h0, 5'd10);
        end
        issue(OP_LW, 32'd10 << 2, 32'h0, 32'h0, 5'd11);
        issue(OP_SB, (32'd10 << 2) + 2, 32'h0, 32'h0000_00a5, 5'd0);
        issue(OP_LBU, (32'd10 << 2) + 2, 32'h0, 32'h0, 5'd12);
        issue(OP_SH, (32'd10 << 2) + 2, 32'h0, 32'h0000_9e01, 5'd0);
        issue(OP_LH, (32'd10 << 2) + 2, 32'h0, 32'h0, 5'd13);
        idle(2);

        // lwl and lwr at every offset over a known register value
        issue(OP_SW, 32'd20 << 2, 32'h0, 32'h4433_2211, 5'd0);
        for (int a = 0; a < 4; a++) begin
            issue(OP_ALU, 32'h0, 32'hcafe_f00d + a, 32'h0, REG_AW'(16 + a));
            issue(OP_LWL, (32'd20 << 2) + a, 32'h0, 32'h0, REG_AW'(16 + a));
            issue(OP_ALU, 32'h0, 32'hbeef_0000 + a, 32'h0, REG_AW'(20 + a));
            issue(OP_LWR, (32'd20 << 2) + a, 32'h0, 32'h0, REG_AW'(20 + a));
        end

        // alu, nop, and writes aimed at register 0
        issue(OP_ALU, 32'h0, 32'h1357_9bdf, 32'h0, 5'd24);
        issue(OP_ALU, 32'h0, 32'hffff_ffff, 32'h0, 5'd0);
        issue(OP_LW, 32'd20 << 2, 32'h0, 32'h0, 5'd0);
        issue(OP_NOP, 32'h0, 32'h0, 32'h0, 5'd25);
        idle(3);

        for (int i = 0; i < N_RAND; i++) begin
            if (rand32() % 8 == 0) idle(1);   // occasional gap
            else random_instr();
        end
        idle(5);
        sweep_regs();

        if (q_pc.size() != 0) begin
            fail_run("write-backs still outstanding at the end of the run");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

//--- list.f
common/lsu_pkg.sv
src/load_decode.sv
mem_stage/mem_stage.sv
wb/load_align.sv
wb/wb_stage.sv
src/reg_file.sv
src/lsu_top.sv
dv/tb_clock.sv
dv/tb_lsu.sv

//--- Bender.yml
package:
  name: lsu_backend

sources:
  - target: rtl
    files:
      - common/lsu_pkg.sv
      - src/load_decode.sv
      - mem_stage/mem_stage.sv
      - wb/load_align.sv
      - wb/wb_stage.sv
      - src/reg_file.sv
      - src/lsu_top.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/tb_lsu.sv
